// File: verilog/cpu_pkg.sv
package cpu_pkg;

  // Datapath widths
  localparam int XLEN       = 64;
  localparam int INSTR_W    = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [REG_ADDR_W-1:0] ZERO_REG = 5'd31; // XZR, reads as zero

  localparam logic [XLEN-1:0] PC_STEP          = 64'd4;
  localparam logic [XLEN-1:0] DEFAULT_RESET_PC = 64'd0;

  // R-format opcodes, instr[31:21]
  localparam logic [10:0] OPC_ADD  = 11'b10001011000;
  localparam logic [10:0] OPC_SUB  = 11'b11001011000;
  localparam logic [10:0] OPC_AND  = 11'b10001010000;
  localparam logic [10:0] OPC_ORR  = 11'b10101010000;
  localparam logic [10:0] OPC_EOR  = 11'b11001010000;

  // D-format opcodes, instr[31:21]
  localparam logic [10:0] OPC_LDUR = 11'b11111000010;
  localparam logic [10:0] OPC_STUR = 11'b11111000000;

  // I-format opcodes, instr[31:22]
  localparam logic [9:0]  OPC_ADDI = 10'b1001000100;
  localparam logic [9:0]  OPC_SUBI = 10'b1101000100;
  localparam logic [9:0]  OPC_ANDI = 10'b1001001000;
  localparam logic [9:0]  OPC_ORRI = 10'b1011001000;
  localparam logic [9:0]  OPC_EORI = 10'b1101001000;

  // ALU operation carried from decode to execute
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0, // Also used for address generation
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_ORR = 3'd3,
    ALU_EOR = 3'd4
  } alu_op_e;

endpackage

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [cpu_pkg::XLEN-1:0]  a,
  input  logic [cpu_pkg::XLEN-1:0]  b,
  input  cpu_pkg::alu_op_e          op,
  output logic [cpu_pkg::XLEN-1:0]  result
);

  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD: result = a + b;
      cpu_pkg::ALU_SUB: result = a - b;
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_ORR: result = a | b;
      cpu_pkg::ALU_EOR: result = a ^ b;
      default:          result = '0; // Unused encodings
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            CLOCK,
  input  logic                            rst_n,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  rs1_addr,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  rs2_addr,
  output logic [cpu_pkg::XLEN-1:0]        rs1_data,
  output logic [cpu_pkg::XLEN-1:0]        rs2_data,
  input  logic                            wb_we,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  wb_rd,
  input  logic [cpu_pkg::XLEN-1:0]        wb_data
);

  logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::NUM_REGS];

  // Read with bypass of the write landing this cycle
  function automatic logic [cpu_pkg::XLEN-1:0] read_port(
    input logic [cpu_pkg::REG_ADDR_W-1:0] addr
  );
    if (addr == cpu_pkg::ZERO_REG) return '0;
    if (wb_we && (wb_rd == addr)) return wb_data;
    return regs[addr];
  endfunction

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
        regs[i] <= cpu_pkg::XLEN'(i); // Xi starts at i
      end
    end else if (wb_we && (wb_rd != cpu_pkg::ZERO_REG)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  a_xzr_reads_zero: assert property (@(posedge CLOCK)
    (rs1_addr == cpu_pkg::ZERO_REG) |-> (rs1_data == '0));

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = cpu_pkg::DEFAULT_RESET_PC
) (
  input  logic                         CLOCK,
  input  logic                         rst_n,
  input  logic                         stall,
  input  logic [cpu_pkg::INSTR_W-1:0]  instr,
  output logic [cpu_pkg::XLEN-1:0]     pc,
  output logic [cpu_pkg::INSTR_W-1:0]  id_instr,
  output logic                         id_valid
);

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!stall) begin
      pc <= pc + cpu_pkg::PC_STEP; // Straight-line fetch only
    end
  end

  // IF/ID control
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      id_valid <= 1'b0;
    end else if (!stall) begin
      id_valid <= 1'b1;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (!stall) begin
      id_instr <= instr; // Held while decode repeats
    end
  end

  // A load-use hold must really freeze fetch for that cycle
  a_pc_hold: assert property (@(posedge CLOCK) disable iff (!rst_n)
    stall |=> $stable(pc));

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                            CLOCK,
  input  logic                            rst_n,
  input  logic [cpu_pkg::INSTR_W-1:0]     id_instr,
  input  logic                            id_valid,
  input  logic [cpu_pkg::XLEN-1:0]        rs1_data,
  input  logic [cpu_pkg::XLEN-1:0]        rs2_data,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  rs1_addr,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  rs2_addr,
  output logic                            stall,
  output logic                            ex_valid,
  output cpu_pkg::alu_op_e                ex_alu_op,
  output logic                            ex_use_imm,
  output logic                            ex_mem_read,
  output logic                            ex_mem_write,
  output logic                            ex_reg_write,
  output logic                            ex_mem_to_reg,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rs1,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rs2,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rd,
  output logic [cpu_pkg::XLEN-1:0]        ex_op_a,
  output logic [cpu_pkg::XLEN-1:0]        ex_op_b,
  output logic [cpu_pkg::XLEN-1:0]        ex_imm
);

  logic [10:0]               opc11;
  logic [9:0]                opc10;
  cpu_pkg::alu_op_e          dec_alu_op;
  logic                      dec_kept;
  logic                      dec_uses_rs2;
  logic                      dec_use_imm;
  logic                      dec_mem_read;
  logic                      dec_mem_write;
  logic                      dec_reg_write;
  logic                      dec_mem_to_reg;
  logic [cpu_pkg::XLEN-1:0]  dec_imm;
  logic                      hit_rs1;
  logic                      hit_rs2;

  assign opc11 = id_instr[31:21];
  assign opc10 = id_instr[31:22];

  assign rs1_addr = id_instr[9:5];
  assign rs2_addr = (opc11 == cpu_pkg::OPC_STUR) ? id_instr[4:0] : id_instr[20:16]; // Rt for STUR

  always_comb begin
    dec_alu_op     = cpu_pkg::ALU_ADD;
    dec_kept       = 1'b0;
    dec_uses_rs2   = 1'b0;
    dec_use_imm    = 1'b0;
    dec_mem_read   = 1'b0;
    dec_mem_write  = 1'b0;
    dec_reg_write  = 1'b0;
    dec_mem_to_reg = 1'b0;
    dec_imm        = {{(cpu_pkg::XLEN-12){1'b0}}, id_instr[21:10]}; // imm12, zero-extended
    case (opc11)
      cpu_pkg::OPC_LDUR, cpu_pkg::OPC_STUR: begin
        dec_kept       = 1'b1;
        dec_use_imm    = 1'b1;
        dec_imm        = {{(cpu_pkg::XLEN-9){id_instr[20]}}, id_instr[20:12]}; // imm9
        dec_mem_read   = (opc11 == cpu_pkg::OPC_LDUR);
        dec_mem_write  = (opc11 == cpu_pkg::OPC_STUR);
        dec_reg_write  = dec_mem_read;
        dec_mem_to_reg = dec_mem_read;
        dec_uses_rs2   = dec_mem_write; // Store data
      end
      cpu_pkg::OPC_ADD, cpu_pkg::OPC_SUB, cpu_pkg::OPC_AND,
      cpu_pkg::OPC_ORR, cpu_pkg::OPC_EOR: begin
        dec_kept      = 1'b1;
        dec_uses_rs2  = 1'b1;
        dec_reg_write = 1'b1;
        case (opc11)
          cpu_pkg::OPC_SUB: dec_alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::OPC_AND: dec_alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OPC_ORR: dec_alu_op = cpu_pkg::ALU_ORR;
          cpu_pkg::OPC_EOR: dec_alu_op = cpu_pkg::ALU_EOR;
          default:          dec_alu_op = cpu_pkg::ALU_ADD;
        endcase
      end
      default: begin
        case (opc10)
          cpu_pkg::OPC_ADDI, cpu_pkg::OPC_SUBI, cpu_pkg::OPC_ANDI,
          cpu_pkg::OPC_ORRI, cpu_pkg::OPC_EORI: begin
            dec_kept      = 1'b1;
            dec_use_imm   = 1'b1;
            dec_reg_write = 1'b1;
          end
          default: dec_kept = 1'b0; // Anything else is a no-op
        endcase
        case (opc10)
          cpu_pkg::OPC_SUBI: dec_alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::OPC_ANDI: dec_alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OPC_ORRI: dec_alu_op = cpu_pkg::ALU_ORR;
          cpu_pkg::OPC_EORI: dec_alu_op = cpu_pkg::ALU_EOR;
          default:           dec_alu_op = cpu_pkg::ALU_ADD;
        endcase
      end
    endcase
  end

  // Load-use against the LDUR now in ID/EX; an XZR target never forwards
  assign hit_rs1 = dec_kept && (rs1_addr == ex_rd);
  assign hit_rs2 = dec_uses_rs2 && (rs2_addr == ex_rd);
  assign stall   = id_valid && ex_valid && ex_mem_read &&
                   (ex_rd != cpu_pkg::ZERO_REG) && (hit_rs1 || hit_rs2);

  // ID/EX control, a stall loads a bubble
  always_ff @(posedge CLOCK) begin
    if (!rst_n || stall) begin
      ex_valid      <= 1'b0;
      ex_mem_read   <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_mem_to_reg <= 1'b0;
    end else begin
      ex_valid      <= id_valid;
      ex_mem_read   <= dec_mem_read;
      ex_mem_write  <= dec_mem_write;
      ex_reg_write  <= dec_reg_write;
      ex_mem_to_reg <= dec_mem_to_reg;
    end
  end

  // ID/EX payload
  always_ff @(posedge CLOCK) begin
    ex_alu_op  <= dec_alu_op;
    ex_use_imm <= dec_use_imm;
    ex_rs1     <= rs1_addr;
    ex_rs2     <= rs2_addr;
    ex_rd      <= id_instr[4:0];
    ex_op_a    <= rs1_data;
    ex_op_b    <= rs2_data;
    ex_imm     <= dec_imm;
  end

  // The bubble clears ex_mem_read, so a hold never lasts two cycles
  a_single_stall: assert property (@(posedge CLOCK) disable iff (!rst_n)
    stall |=> !stall);

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                            CLOCK,
  input  logic                            rst_n,
  input  logic                            ex_valid,
  input  cpu_pkg::alu_op_e                ex_alu_op,
  input  logic                            ex_use_imm,
  input  logic                            ex_mem_read,
  input  logic                            ex_mem_write,
  input  logic                            ex_reg_write,
  input  logic                            ex_mem_to_reg,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rs1,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rs2,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rd,
  input  logic [cpu_pkg::XLEN-1:0]        ex_op_a,
  input  logic [cpu_pkg::XLEN-1:0]        ex_op_b,
  input  logic [cpu_pkg::XLEN-1:0]        ex_imm,
  input  logic                            wb_we,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  wb_rd,
  input  logic [cpu_pkg::XLEN-1:0]        wb_data,
  output logic [cpu_pkg::XLEN-1:0]        mem_addr,
  output logic [cpu_pkg::XLEN-1:0]        mem_wdata,
  output logic                            mem_read,
  output logic                            mem_write,
  output logic                            mem_reg_write,
  output logic                            mem_to_reg,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  mem_rd
);

  logic [cpu_pkg::XLEN-1:0] fwd_a;
  logic [cpu_pkg::XLEN-1:0] fwd_b;
  logic [cpu_pkg::XLEN-1:0] alu_b;
  logic [cpu_pkg::XLEN-1:0] alu_result;

  // Producer writes a real register that this operand reads
  function automatic logic fwd_hit(
    input logic                           we,
    input logic [cpu_pkg::REG_ADDR_W-1:0] rd,
    input logic [cpu_pkg::REG_ADDR_W-1:0] src
  );
    return we && (rd != cpu_pkg::ZERO_REG) && (rd == src);
  endfunction

  // Youngest producer wins
  assign fwd_a = fwd_hit(mem_reg_write, mem_rd, ex_rs1) ? mem_addr :
                 fwd_hit(wb_we, wb_rd, ex_rs1)           ? wb_data  : ex_op_a;
  assign fwd_b = fwd_hit(mem_reg_write, mem_rd, ex_rs2) ? mem_addr :
                 fwd_hit(wb_we, wb_rd, ex_rs2)           ? wb_data  : ex_op_b;

  assign alu_b = ex_use_imm ? ex_imm : fwd_b;

  alu u_alu (
    .a(fwd_a),
    .b(alu_b),
    .op(ex_alu_op),
    .result(alu_result)
  );

  // EX/MEM control
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      mem_read      <= 1'b0;
      mem_write     <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_to_reg    <= 1'b0;
    end else begin
      mem_read      <= ex_valid && ex_mem_read;
      mem_write     <= ex_valid && ex_mem_write;
      mem_reg_write <= ex_valid && ex_reg_write;
      mem_to_reg    <= ex_valid && ex_mem_to_reg;
    end
  end

  // EX/MEM payload
  always_ff @(posedge CLOCK) begin
    mem_addr  <= alu_result; // Also the ALU result for writeback
    mem_wdata <= fwd_b;      // Store data after forwarding
    mem_rd    <= ex_rd;
  end

  a_one_mem_op: assert property (@(posedge CLOCK) disable iff (!rst_n)
    !(mem_read && mem_write));

endmodule

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
  input  logic                            CLOCK,
  input  logic                            rst_n,
  input  logic [cpu_pkg::XLEN-1:0]        mem_rdata,
  input  logic [cpu_pkg::XLEN-1:0]        mem_addr,
  input  logic                            mem_reg_write,
  input  logic                            mem_to_reg,
  input  logic [cpu_pkg::REG_ADDR_W-1:0]  mem_rd,
  output logic                            wb_we,
  output logic [cpu_pkg::REG_ADDR_W-1:0]  wb_rd,
  output logic [cpu_pkg::XLEN-1:0]        wb_data
);

  logic [cpu_pkg::XLEN-1:0] alu_q;
  logic [cpu_pkg::XLEN-1:0] load_q;
  logic                     sel_load;

  // MEM/WB control
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      wb_we    <= 1'b0;
      sel_load <= 1'b0;
    end else begin
      wb_we    <= mem_reg_write;
      sel_load <= mem_to_reg;
    end
  end

  always_ff @(posedge CLOCK) begin
    alu_q  <= mem_addr;
    load_q <= mem_rdata; // Sampled in the MEM cycle
    wb_rd  <= mem_rd;
  end

  assign wb_data = sel_load ? load_q : alu_q; // LDUR takes the loaded word

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = cpu_pkg::DEFAULT_RESET_PC
) (
  input  logic                         CLOCK,
  input  logic                         rst_n,
  output logic [cpu_pkg::XLEN-1:0]     pc,
  input  logic [cpu_pkg::INSTR_W-1:0]  instr,
  output logic [cpu_pkg::XLEN-1:0]     mem_addr,
  output logic [cpu_pkg::XLEN-1:0]     mem_wdata,
  output logic                         mem_read,
  output logic                         mem_write,
  input  logic [cpu_pkg::XLEN-1:0]     mem_rdata
);

  // IF/ID
  logic                            stall;
  logic [cpu_pkg::INSTR_W-1:0]     id_instr;
  logic                            id_valid;

  // Register file reads
  logic [cpu_pkg::REG_ADDR_W-1:0]  rs1_addr;
  logic [cpu_pkg::REG_ADDR_W-1:0]  rs2_addr;
  logic [cpu_pkg::XLEN-1:0]        rs1_data;
  logic [cpu_pkg::XLEN-1:0]        rs2_data;

  // ID/EX
  logic                            ex_valid;
  cpu_pkg::alu_op_e                ex_alu_op;
  logic                            ex_use_imm;
  logic                            ex_mem_read;
  logic                            ex_mem_write;
  logic                            ex_reg_write;
  logic                            ex_mem_to_reg;
  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rs1;
  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rs2;
  logic [cpu_pkg::REG_ADDR_W-1:0]  ex_rd;
  logic [cpu_pkg::XLEN-1:0]        ex_op_a;
  logic [cpu_pkg::XLEN-1:0]        ex_op_b;
  logic [cpu_pkg::XLEN-1:0]        ex_imm;

  // EX/MEM and MEM/WB
  logic                            mem_reg_write;
  logic                            mem_to_reg;
  logic [cpu_pkg::REG_ADDR_W-1:0]  mem_rd;
  logic                            wb_we;
  logic [cpu_pkg::REG_ADDR_W-1:0]  wb_rd;
  logic [cpu_pkg::XLEN-1:0]        wb_data;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .CLOCK(CLOCK), .rst_n(rst_n), .stall(stall), .instr(instr),
    .pc(pc), .id_instr(id_instr), .id_valid(id_valid)
  );

  decode_stage u_decode (
    .CLOCK(CLOCK), .rst_n(rst_n), .id_instr(id_instr), .id_valid(id_valid),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .stall(stall),
    .ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg),
    .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
    .ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_imm(ex_imm)
  );

  reg_file u_reg_file (
    .CLOCK(CLOCK), .rst_n(rst_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  execute_stage u_execute (
    .CLOCK(CLOCK), .rst_n(rst_n),
    .ex_valid(ex_valid), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
    .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
    .ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg),
    .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
    .ex_op_a(ex_op_a), .ex_op_b(ex_op_b), .ex_imm(ex_imm),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write),
    .mem_reg_write(mem_reg_write), .mem_to_reg(mem_to_reg), .mem_rd(mem_rd)
  );

  writeback_stage u_writeback (
    .CLOCK(CLOCK), .rst_n(rst_n), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
    .mem_reg_write(mem_reg_write), .mem_to_reg(mem_to_reg), .mem_rd(mem_rd),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
  );

endmodule

// File: sim/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int PROG_LEN   = 64;
localparam int IMEM_WORDS = 128;

logic [31:0] lfsr_state = 32'ha8db_4d7d;
logic [31:0] imem [IMEM_WORDS];
logic [63:0] exp_addr_q [$];
logic [63:0] exp_data_q [$];
int          exp_stalls = 0;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return v;
endfunction

function automatic logic [4:0] pick_reg();
  logic [4:0] r;
  r = 5'(take_bits(3)); // X0..X7 keeps dependencies dense
  if (take_bits(3) == 32'd0) r = 5'd31; // Occasional XZR
  return r;
endfunction

function automatic logic [63:0] fill_word(input logic [63:0] addr);
  return addr * 64'd5; // Unwritten data memory
endfunction

function automatic logic [63:0] alu_model(input logic [31:0] w, input logic [63:0] a,
                                          input logic [63:0] b);
  if (w[31:21] == cpu_pkg::OPC_SUB || w[31:22] == cpu_pkg::OPC_SUBI) return a - b;
  if (w[31:21] == cpu_pkg::OPC_AND || w[31:22] == cpu_pkg::OPC_ANDI) return a & b;
  if (w[31:21] == cpu_pkg::OPC_ORR || w[31:22] == cpu_pkg::OPC_ORRI) return a | b;
  if (w[31:21] == cpu_pkg::OPC_EOR || w[31:22] == cpu_pkg::OPC_EORI) return a ^ b;
  return a + b;
endfunction

task automatic build_program();
  logic [3:0]  kind;
  logic [4:0]  rd;
  logic [4:0]  rn;
  logic [4:0]  rm;
  logic [11:0] imm12;
  logic [8:0]  imm9;
  int          n;
  for (int i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = 32'd0; // Zero words decode as no-ops
  end
  n = 0;
  while (n < PROG_LEN) begin
    kind  = 4'(take_bits(4));
    rd    = pick_reg();
    rn    = pick_reg();
    rm    = pick_reg();
    imm12 = 12'(take_bits(12));
    imm9  = 9'(take_bits(9));
    case (kind)
      4'd0:         imem[n] = {cpu_pkg::OPC_ADD, rm, 6'd0, rn, rd};
      4'd1:         imem[n] = {cpu_pkg::OPC_SUB, rm, 6'd0, rn, rd};
      4'd2:         imem[n] = {cpu_pkg::OPC_AND, rm, 6'd0, rn, rd};
      4'd3:         imem[n] = {cpu_pkg::OPC_ORR, rm, 6'd0, rn, rd};
      4'd4:         imem[n] = {cpu_pkg::OPC_EOR, rm, 6'd0, rn, rd};
      4'd5:         imem[n] = {cpu_pkg::OPC_ADDI, imm12, rn, rd};
      4'd6:         imem[n] = {cpu_pkg::OPC_SUBI, imm12, rn, rd};
      4'd7:         imem[n] = {cpu_pkg::OPC_ANDI, imm12, rn, rd};
      4'd8:         imem[n] = {cpu_pkg::OPC_ORRI, imm12, rn, rd};
      4'd9:         imem[n] = {cpu_pkg::OPC_EORI, imm12, rn, rd};
      4'd10, 4'd11: imem[n] = {cpu_pkg::OPC_LDUR, imm9, 2'b00, rn, rd};
      default:      imem[n] = {cpu_pkg::OPC_STUR, imm9, 2'b00, rn, rd};
    endcase
    n++;
    if (kind == 4'd11 && n < PROG_LEN) begin
      rn      = pick_reg();
      imem[n] = {cpu_pkg::OPC_STUR, imm9, 2'b00, rn, rd}; // Stores the loaded value at once
      n++;
    end
  end
endtask

// In-order execution of the program, one instruction at a time
task automatic run_model();
  logic [63:0] x [32];
  logic [63:0] dmem [logic [63:0]];
  logic [31:0] w;
  logic [4:0]  rd;
  logic [4:0]  rn;
  logic [4:0]  load_rd;
  logic [2:0]  kind;
  logic [63:0] b;
  logic [63:0] res;
  logic [63:0] addr;
  for (int i = 0; i < 32; i++) begin
    x[i] = (i == 31) ? 64'd0 : 64'(i);
  end
  load_rd = 5'd31;
  for (int i = 0; i < PROG_LEN; i++) begin
    w  = imem[i];
    rd = w[4:0];
    rn = w[9:5];
    // 0 no-op, 1 register form, 2 immediate form, 3 load, 4 store
    case (w[31:21])
      cpu_pkg::OPC_ADD, cpu_pkg::OPC_SUB, cpu_pkg::OPC_AND,
      cpu_pkg::OPC_ORR, cpu_pkg::OPC_EOR: kind = 3'd1;
      cpu_pkg::OPC_LDUR:                  kind = 3'd3;
      cpu_pkg::OPC_STUR:                  kind = 3'd4;
      default: begin
        case (w[31:22])
          cpu_pkg::OPC_ADDI, cpu_pkg::OPC_SUBI, cpu_pkg::OPC_ANDI,
          cpu_pkg::OPC_ORRI, cpu_pkg::OPC_EORI: kind = 3'd2;
          default:                              kind = 3'd0;
        endcase
      end
    endcase
    if (kind != 3'd0 && load_rd != 5'd31 && (rn == load_rd ||
        (kind == 3'd1 && w[20:16] == load_rd) || (kind == 3'd4 && rd == load_rd))) begin
      exp_stalls++; // Reads the register loaded just before
    end
    load_rd = (kind == 3'd3) ? rd : 5'd31;
    b       = (kind == 3'd2) ? {52'd0, w[21:10]} : x[w[20:16]];
    addr    = x[rn] + {{55{w[20]}}, w[20:12]};
    res     = alu_model(w, x[rn], b);
    if (kind == 3'd3) res = dmem.exists(addr) ? dmem[addr] : fill_word(addr);
    if (kind == 3'd4) begin
      dmem[addr] = x[rd];
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(x[rd]);
    end else if (kind != 3'd0 && rd != 5'd31) begin
      x[rd] = res; // XZR stays zero
    end
  end
endtask

`endif

// File: sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

  `include "cpu_model.svh"

  localparam logic [63:0] RESET_PC    = cpu_pkg::DEFAULT_RESET_PC;
  localparam logic [63:0] END_PC      = RESET_PC + 64'((PROG_LEN + 8) * 4); // Program plus drain
  localparam int          WAIT_CYCLES = 400;

  logic        CLOCK     = 1'b0;
  logic        rst_n     = 1'b0;
  logic [31:0] instr     = 32'd0;
  logic [63:0] mem_rdata = 64'd0;
  logic [63:0] pc;
  logic [63:0] mem_addr;
  logic [63:0] mem_wdata;
  logic        mem_read;
  logic        mem_write;

  logic [63:0] data_mem [logic [63:0]];
  logic [63:0] last_pc     = RESET_PC;
  logic        tracking    = 1'b0;
  int          checks      = 0;
  int          mismatches  = 0;
  int          failures    = 0;
  int          stores_seen = 0;
  int          store_total = 0;
  int          pc_repeats  = 0;

  cpu_top #(.RESET_PC(RESET_PC)) u_cpu_top (
    .CLOCK(CLOCK), .rst_n(rst_n), .pc(pc), .instr(instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read),
    .mem_write(mem_write), .mem_rdata(mem_rdata)
  );

  always #20 CLOCK = ~CLOCK;

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Memory answers for the cycle that just started
  always @(posedge CLOCK) begin
    #2;
    instr     = (pc[63:9] == '0) ? imem[pc[8:2]] : 32'd0;
    mem_rdata = !mem_read ? 64'd0 :
                data_mem.exists(mem_addr) ? data_mem[mem_addr] : fill_word(mem_addr);
  end

  // Mid-cycle, where DUT outputs are settled
  always @(negedge CLOCK) begin
    if (tracking) begin
      if (mem_write) begin
        data_mem[mem_addr] = mem_wdata; // Lands before the edge that ends the MEM cycle
        stores_seen++;
        if (exp_addr_q.size() == 0) begin
          failures++;
          $display("Unexpected store of %h to address %h", mem_wdata, mem_addr);
        end else begin
          check_value("store addr", exp_addr_q.pop_front(), mem_addr);
          check_value("store data", exp_data_q.pop_front(), mem_wdata);
        end
      end
      if (pc == last_pc) begin
        pc_repeats++; // Load-use hold
      end else begin
        check_value("pc step", last_pc + cpu_pkg::PC_STEP, pc);
      end
      last_pc = pc;
    end
  end

  initial begin
    int cycles;
    build_program();
    run_model();
    store_total = exp_addr_q.size();
    for (int i = 0; i < 8; i++) begin
      @(posedge CLOCK);
      #2;
      if (i == 7) rst_n = 1'b1;
      @(negedge CLOCK);
      check_value("reset pc", RESET_PC, pc);
      check_value("reset mem_read", 64'd0, 64'(mem_read));
      check_value("reset mem_write", 64'd0, 64'(mem_write));
    end
    @(posedge CLOCK);
    tracking = 1'b1;
    cycles   = 0;
    while ((stores_seen < store_total || last_pc < END_PC) && cycles < WAIT_CYCLES) begin
      @(posedge CLOCK);
      cycles++;
    end
    if (cycles >= WAIT_CYCLES) begin
      failures++;
      $display("Timeout: the program did not finish within %0d cycles", WAIT_CYCLES);
    end
    check_value("store count", 64'(store_total), 64'(stores_seen));
    check_value("load-use stalls", 64'(exp_stalls), 64'(pc_repeats));
    $display("Checks: %0d, mismatches: %0d, other failures: %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+sim
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/cpu_top.sv
sim/cpu_tb.sv
